//--- build.f
hdl/enemyPkg.sv
hdl/enemyMover.sv
hdl/enemyHitTest.sv
hdl/enemyPrioritySelect.sv
hdl/enemyStockManager.sv
tb/enemyStock_sva.sv
tb/enemyStockTb.sv

//--- hdl/enemyHitTest.sv
/*
  Registered test of the current pixel against one enemy.
  All boxes are half-open: left and top edges inside, right and bottom outside.
  Zones reaching past coordinate 0 are clipped there. A dead enemy never hits.
*/

`timescale 1ns/1ns

module enemyHitTest import enemyPkg::*; (
	input  logic     clk,
	input  logic     rstN,
	input  pixelT    pixel,
	input  enemyPosT pos,
	output enemyHitT hit
);

	// widened by one bit so sums near the screen edge stay exact
	logic [11:0] px;
	logic [11:0] py;
	logic [11:0] ex;
	logic [11:0] ey;

	logic bodyCols;
	logic bodyRows;
	logic upCols;
	logic upRows;
	logic downCols;
	logic downRows;

	logic inBody;
	logic inUp;
	logic inDown;

	always_comb begin
		px = {1'b0, pixel.x};
		py = {1'b0, pixel.y};
		ex = {1'b0, pos.x};
		ey = {1'b0, pos.y};

		bodyCols = (px >= ex) && (px < ex + 12'(ENEMY_WIDTH));
		bodyRows = (py >= ey) && (py < ey + 12'(ENEMY_HEIGHT));

		// comparing px + margin avoids going negative near x = 0
		upCols = (px + 12'(HEADS_UP_MARGIN) >= ex)
			&& (px < ex + 12'(ENEMY_WIDTH + HEADS_UP_MARGIN));
		upRows = (py < ey) && (py + 12'(HEADS_UP_HEIGHT) >= ey);

		downCols = (px + 12'(HEADS_DOWN_MARGIN) >= ex)
			&& (px < ex + 12'(ENEMY_WIDTH + HEADS_DOWN_MARGIN));
		downRows = (py >= ey + 12'(ENEMY_HEIGHT))
			&& (py < ey + 12'(ENEMY_HEIGHT + HEADS_DOWN_HEIGHT));

		inBody = pos.alive && bodyCols && bodyRows;
		inUp   = pos.alive && upCols && upRows;
		inDown = pos.alive && downCols && downRows;
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			hit <= '0;
		end else begin
			hit.body      <= inBody;
			hit.headsUp   <= inUp;
			hit.headsDown <= inDown;
			if (inBody) begin
				hit.offsetX <= pixel.x - pos.x;
				hit.offsetY <= pixel.y - pos.y;
			end else begin
				hit.offsetX <= '0;
				hit.offsetY <= '0;
			end
		end
	end

endmodule

//--- hdl/enemyMover.sv
/*
  Position, direction and alive state of one enemy.
  index must be tied to a constant; it selects the start corner.
  newLevel beats shotHit, and a dead enemy ignores everything except newLevel.
  Every update shows on pos one cycle after its cause.
*/

`timescale 1ns/1ns

module enemyMover import enemyPkg::*; (
	input  logic     clk,
	input  logic     rstN,
	input  enemyIdT  index,
	input  logic     startOfFrame,
	input  logic     pause,
	input  logic     newLevel,
	input  speedT    speed,
	input  logic     changeDir,
	input  logic     dodge,
	input  logic     shotHit,
	output enemyPosT pos
);

	coordT posX;
	coordT posY;
	logic  alive;
	logic  dirRight;

	coordT nextX;
	coordT nextY;
	logic  nextAlive;
	logic  nextDirRight;

	// 12 bits so the edge tests cannot wrap
	logic [11:0] rightSum;
	logic [11:0] leftLimit;

	always_comb begin
		rightSum  = {1'b0, posX} + {1'b0, speed};
		leftLimit = {1'b0, speed} + 12'(LEFT_EDGE);
	end

	always_comb begin
		nextX        = posX;
		nextY        = posY;
		nextAlive    = alive;
		nextDirRight = dirRight;

		if (newLevel) begin
			nextX        = INIT_X[index];
			nextY        = INIT_Y[index];
			nextAlive    = 1'b1;
			nextDirRight = 1'b1;
		end else if (shotHit) begin
			nextAlive = 1'b0;
		end else if (alive) begin
			if (changeDir) begin
				nextDirRight = !dirRight;
			end

			if (dodge) begin
				if ({1'b0, posY} < 12'(TOP_EDGE + DODGE_STEP)) begin
					nextY = coordT'(TOP_EDGE);
				end else begin
					nextY = posY - coordT'(DODGE_STEP);
				end
			end

			// frame motion uses the direction after any changeDir
			if (startOfFrame && !pause) begin
				if (nextDirRight) begin
					if (rightSum > 12'(RIGHT_EDGE)) begin
						nextX        = coordT'(RIGHT_EDGE);
						nextDirRight = 1'b0;
					end else begin
						nextX = rightSum[10:0];
					end
				end else begin
					if (leftLimit > {1'b0, posX}) begin
						nextX        = coordT'(LEFT_EDGE);
						nextDirRight = 1'b1;
					end else begin
						nextX = posX - speed;
					end
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			posX     <= INIT_X[index];
			posY     <= INIT_Y[index];
			alive    <= 1'b1;
			dirRight <= 1'b1;
		end else begin
			posX     <= nextX;
			posY     <= nextY;
			alive    <= nextAlive;
			dirRight <= nextDirRight;
		end
	end

	always_comb begin
		pos.x     = posX;
		pos.y     = posY;
		pos.alive = alive;
	end

endmodule

//--- hdl/enemyPkg.sv
/*
  Shared geometry, start positions and pipeline types for the enemy block.
  Coordinates are 11-bit unsigned screen values with the origin at the top left.
  The start tables hold exactly NUM_ENEMIES entries and must grow with it.
*/

package enemyPkg;

	localparam int NUM_ENEMIES = 4;

	// body size in pixels
	localparam int ENEMY_WIDTH  = 20;
	localparam int ENEMY_HEIGHT = 20;

	// sense zones above and below the body
	localparam int HEADS_UP_HEIGHT   = 80;
	localparam int HEADS_DOWN_HEIGHT = 80;
	localparam int HEADS_UP_MARGIN   = 8;
	localparam int HEADS_DOWN_MARGIN = 11;

	// travel limits for the top-left corner
	localparam int LEFT_EDGE  = 30;
	localparam int RIGHT_EDGE = 580;
	localparam int TOP_EDGE   = 20;
	localparam int DODGE_STEP = 16;

	typedef logic [10:0] coordT;
	typedef logic [$clog2(NUM_ENEMIES)-1:0] enemyIdT;
	typedef logic [10:0] speedT;

	// start corner per enemy, 100 * (index + 1)
	localparam coordT INIT_X [NUM_ENEMIES] = '{11'd100, 11'd200, 11'd300, 11'd400};
	localparam coordT INIT_Y [NUM_ENEMIES] = '{11'd100, 11'd200, 11'd300, 11'd400};

	typedef struct packed {
		coordT x;
		coordT y;
	} pixelT;

	typedef struct packed {
		coordT x;
		coordT y;
		logic  alive;
	} enemyPosT;

	typedef struct packed {
		logic  body;
		logic  headsUp;
		logic  headsDown;
		coordT offsetX;
		coordT offsetY;
	} enemyHitT;

	typedef struct packed {
		logic    enemyDrawReq;
		logic    headsUpDrawReq;
		logic    headsDownDrawReq;
		enemyIdT requestorId;
		coordT   offsetX;
		coordT   offsetY;
	} drawReqT;

endpackage

//--- hdl/enemyPrioritySelect.sv
/*
  Registered merge of all per-enemy hits into one draw request.
  Class order is body, then headsUp, then headsDown; within a class the
  highest index wins. A body hit masks headsUpDrawReq.
*/

`timescale 1ns/1ns

module enemyPrioritySelect import enemyPkg::*; (
	input  logic     clk,
	input  logic     rstN,
	input  enemyHitT hits [NUM_ENEMIES],
	output drawReqT  drawReq
);

	drawReqT nextReq;

	// later loops overwrite the id, so the stronger class is applied last
	always_comb begin
		nextReq = '0;

		for (int i = 0; i < NUM_ENEMIES; i++) begin
			if (hits[i].headsDown) begin
				nextReq.headsDownDrawReq = 1'b1;
				nextReq.requestorId      = enemyIdT'(i);
			end
		end

		for (int i = 0; i < NUM_ENEMIES; i++) begin
			if (hits[i].headsUp) begin
				nextReq.headsUpDrawReq = 1'b1;
				nextReq.requestorId    = enemyIdT'(i);
			end
		end

		for (int i = 0; i < NUM_ENEMIES; i++) begin
			if (hits[i].body) begin
				nextReq.enemyDrawReq   = 1'b1;
				nextReq.headsUpDrawReq = 1'b0;
				nextReq.requestorId    = enemyIdT'(i);
				nextReq.offsetX        = hits[i].offsetX;
				nextReq.offsetY        = hits[i].offsetY;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			drawReq <= '0;
		end else begin
			drawReq <= nextReq;
		end
	end

endmodule

//--- hdl/enemyStockManager.sv
/*
  Enemy stock: NUM_ENEMIES movers, a hit test per enemy and one priority merge.
  drawReq follows pixel by exactly 2 cycles; the scan never stalls.
  changeDir, dodge and shotHit go to the enemy named on drawReq and are
  dropped while no request flag is set.
*/

`timescale 1ns/1ns

module enemyStockManager import enemyPkg::*; (
	input  logic    clk,
	input  logic    rstN,
	input  logic    startOfFrame,
	input  pixelT   pixel,
	input  logic    changeDir,
	input  logic    dodge,
	input  logic    shotHit,
	input  logic    pause,
	input  speedT   speed,
	input  logic    newLevel,
	output drawReqT drawReq
);

	enemyPosT enemyPos  [NUM_ENEMIES];
	enemyHitT enemyHits [NUM_ENEMIES];

	logic anyReq;

	logic [NUM_ENEMIES-1:0] routedChangeDir;
	logic [NUM_ENEMIES-1:0] routedDodge;
	logic [NUM_ENEMIES-1:0] routedShotHit;

	always_comb begin
		anyReq = drawReq.enemyDrawReq || drawReq.headsUpDrawReq
			|| drawReq.headsDownDrawReq;
	end

	genvar i;
	generate
		for (i = 0; i < NUM_ENEMIES; i++) begin : genEnemy
			logic selected;

			// strobes only reach the enemy currently named on the output
			assign selected           = anyReq && (drawReq.requestorId == enemyIdT'(i));
			assign routedChangeDir[i] = changeDir && selected;
			assign routedDodge[i]     = dodge && selected;
			assign routedShotHit[i]   = shotHit && selected;

			enemyMover mover (
				.clk         (clk),
				.rstN        (rstN),
				.index       (enemyIdT'(i)),
				.startOfFrame(startOfFrame),
				.pause       (pause),
				.newLevel    (newLevel),
				.speed       (speed),
				.changeDir   (routedChangeDir[i]),
				.dodge       (routedDodge[i]),
				.shotHit     (routedShotHit[i]),
				.pos         (enemyPos[i])
			);

			enemyHitTest hitTest (
				.clk  (clk),
				.rstN (rstN),
				.pixel(pixel),
				.pos  (enemyPos[i]),
				.hit  (enemyHits[i])
			);
		end
	endgenerate

	enemyPrioritySelect select (
		.clk    (clk),
		.rstN   (rstN),
		.hits   (enemyHits),
		.drawReq(drawReq)
	);

endmodule

//--- tb/enemyStockTb.sv
/*
  Random regression for the enemy block against a cycle model of the movers.
  The model predicts drawReq 2 cycles after each pixel and routes event
  strobes from its own prediction. Stops at the first mismatch.
*/

`timescale 1ns/1ns

module enemyStockTb import enemyPkg::*; ();

	localparam int RESET_CYCLES   = 4;
	localparam int SWEEP_CYCLES   = 400;
	localparam int MOTION_CYCLES  = 2000;
	localparam int ZONE_CYCLES    = 1500;
	localparam int EVENT_CYCLES   = 1500;
	localparam int SHOT_CYCLES    = 1500;
	localparam int DRAIN_CYCLES   = 2;
	localparam int TOTAL_CYCLES   = RESET_CYCLES + SWEEP_CYCLES + MOTION_CYCLES
		+ ZONE_CYCLES + EVENT_CYCLES + SHOT_CYCLES + DRAIN_CYCLES;
	localparam int TIMEOUT_CYCLES = TOTAL_CYCLES * 3 / 2;

	logic    clk;
	logic    rstN;
	logic    startOfFrame;
	pixelT   pixel;
	logic    changeDir;
	logic    dodge;
	logic    shotHit;
	logic    pause;
	speedT   speed;
	logic    newLevel;
	drawReqT drawReq;

	// reference state of every enemy
	int modelX [NUM_ENEMIES];
	int modelY [NUM_ENEMIES];
	bit modelAlive [NUM_ENEMIES];
	bit modelRight [NUM_ENEMIES];

	// predicted drawReq for the current and the next cycle
	drawReqT pipe [2];

	logic [31:0] rngState;
	int cycleCount = 0;

	enemyStockManager uut (
		.clk         (clk),
		.rstN        (rstN),
		.startOfFrame(startOfFrame),
		.pixel       (pixel),
		.changeDir   (changeDir),
		.dodge       (dodge),
		.shotHit     (shotHit),
		.pause       (pause),
		.speed       (speed),
		.newLevel    (newLevel),
		.drawReq     (drawReq)
	);

	always #50 clk = !clk;

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= TIMEOUT_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Regression failed");
			$fatal(1, "run stopped by the cycle limit");
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] state);
		logic [31:0] v;
		v = state;
		v ^= v << 13;
		v ^= v >> 17;
		v ^= v << 5;
		return v;
	endfunction

	function automatic int randBelow(input int limit);
		rngState = xorshift(rngState);
		return int'(rngState % limit);
	endfunction

	function automatic bit inBox(input int px, input int py, input int left, input int top,
			input int right, input int bottom);
		return (px >= left) && (px < right) && (py >= top) && (py < bottom);
	endfunction

	// hits and priority merge for one pixel against the model positions
	function automatic drawReqT predictRequest(input pixelT px);
		drawReqT req;
		int x;
		int y;
		int bodyId;
		int upId;
		int downId;
		x = int'(px.x);
		y = int'(px.y);
		bodyId = -1;
		upId = -1;
		downId = -1;
		for (int i = 0; i < NUM_ENEMIES; i++) begin
			if (modelAlive[i]) begin
				if (inBox(x, y, modelX[i], modelY[i], modelX[i] + ENEMY_WIDTH,
						modelY[i] + ENEMY_HEIGHT))
					bodyId = i;
				if (inBox(x, y, modelX[i] - HEADS_UP_MARGIN, modelY[i] - HEADS_UP_HEIGHT,
						modelX[i] + ENEMY_WIDTH + HEADS_UP_MARGIN, modelY[i]))
					upId = i;
				if (inBox(x, y, modelX[i] - HEADS_DOWN_MARGIN, modelY[i] + ENEMY_HEIGHT,
						modelX[i] + ENEMY_WIDTH + HEADS_DOWN_MARGIN,
						modelY[i] + ENEMY_HEIGHT + HEADS_DOWN_HEIGHT))
					downId = i;
			end
		end
		req = '0;
		req.enemyDrawReq = (bodyId >= 0);
		req.headsUpDrawReq = (upId >= 0) && (bodyId < 0);
		req.headsDownDrawReq = (downId >= 0);
		if (bodyId >= 0) begin
			req.requestorId = enemyIdT'(bodyId);
			req.offsetX = coordT'(x - modelX[bodyId]);
			req.offsetY = coordT'(y - modelY[bodyId]);
		end else if (upId >= 0) begin
			req.requestorId = enemyIdT'(upId);
		end else if (downId >= 0) begin
			req.requestorId = enemyIdT'(downId);
		end
		return req;
	endfunction

	task automatic resetModel();
		for (int i = 0; i < NUM_ENEMIES; i++) begin
			modelX[i] = 100 * (i + 1);
			modelY[i] = 100 * (i + 1);
			modelAlive[i] = 1'b1;
			modelRight[i] = 1'b1;
		end
	endtask

	// one clock of every enemy; strobes go to the enemy named on route
	task automatic stepModel(input drawReqT route, input logic sof, input logic cd,
			input logic dg, input logic sh, input logic ps, input logic nl, input speedT sp);
		bit selected;
		int s;
		s = int'(sp);
		if (nl) begin
			resetModel();
			return;
		end
		for (int i = 0; i < NUM_ENEMIES; i++) begin
			selected = (route.enemyDrawReq || route.headsUpDrawReq || route.headsDownDrawReq)
				&& (int'(route.requestorId) == i);
			if (sh && selected) begin
				modelAlive[i] = 1'b0;
			end else if (modelAlive[i]) begin
				if (cd && selected)
					modelRight[i] = !modelRight[i];
				if (dg && selected)
					modelY[i] = (modelY[i] - DODGE_STEP < TOP_EDGE) ? TOP_EDGE
						: modelY[i] - DODGE_STEP;
				if (sof && !ps) begin
					if (modelRight[i] && modelX[i] + s > RIGHT_EDGE) begin
						modelX[i] = RIGHT_EDGE;
						modelRight[i] = 1'b0;
					end else if (modelRight[i]) begin
						modelX[i] = modelX[i] + s;
					end else if (modelX[i] - s < LEFT_EDGE) begin
						modelX[i] = LEFT_EDGE;
						modelRight[i] = 1'b1;
					end else begin
						modelX[i] = modelX[i] - s;
					end
				end
			end
		end
	endtask

	task automatic checkValue(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("MISMATCH %s expected 0x%0h actual 0x%0h", name, expected, actual);
			$display("Regression failed");
			$fatal(1, "stopping at the first mismatch");
		end
	endtask

	task automatic checkOutput(input drawReqT expected);
		checkValue("drawReq.enemyDrawReq", expected.enemyDrawReq, drawReq.enemyDrawReq);
		checkValue("drawReq.headsUpDrawReq", expected.headsUpDrawReq, drawReq.headsUpDrawReq);
		checkValue("drawReq.headsDownDrawReq", expected.headsDownDrawReq,
			drawReq.headsDownDrawReq);
		checkValue("drawReq.requestorId", expected.requestorId, drawReq.requestorId);
		checkValue("drawReq.offsetX", expected.offsetX, drawReq.offsetX);
		checkValue("drawReq.offsetY", expected.offsetY, drawReq.offsetY);
	endtask

	task automatic runCycle(input pixelT px, input logic sof, input logic cd, input logic dg,
			input logic sh, input logic ps, input logic nl, input speedT sp);
		drawReqT expected;
		@(posedge clk);
		pixel <= px;
		startOfFrame <= sof;
		changeDir <= cd;
		dodge <= dg;
		shotHit <= sh;
		pause <= ps;
		newLevel <= nl;
		speed <= sp;
		expected = pipe[0];
		pipe[0] = pipe[1];
		pipe[1] = predictRequest(px);
		stepModel(expected, sof, cd, dg, sh, ps, nl, sp);
		@(negedge clk);
		checkOutput(expected);
	endtask

	function automatic pixelT pixelNear(input int id);
		pixelT px;
		int x;
		int y;
		x = modelX[id] + randBelow(60) - 20;
		y = modelY[id] + randBelow(220) - 100;
		if (x < 0)
			x = 0;
		if (y < 0)
			y = 0;
		px.x = coordT'(x);
		px.y = coordT'(y);
		return px;
	endfunction

	task automatic randomPhase(input int cycles, input int sofPct, input int pausePct,
			input int eventPct, input int shotPct, input int levelPct);
		logic ps;
		speedT sp;
		ps = 1'b0;
		sp = speedT'(1 + randBelow(24));
		for (int n = 0; n < cycles; n++) begin
			if (randBelow(100) < pausePct)
				ps = !ps;
			if (randBelow(64) == 0)
				sp = speedT'(1 + randBelow(24));
			runCycle(pixelNear(randBelow(NUM_ENEMIES)), randBelow(100) < sofPct,
				randBelow(100) < eventPct, randBelow(100) < eventPct,
				randBelow(100) < shotPct, ps, randBelow(100) < levelPct, sp);
		end
	endtask

	initial begin
		pixelT px;
		clk = 1'b0;
		rstN = 1'b0;
		startOfFrame = 1'b0;
		pixel = '0;
		changeDir = 1'b0;
		dodge = 1'b0;
		shotHit = 1'b0;
		pause = 1'b0;
		speed = speedT'(4);
		newLevel = 1'b0;
		rngState = 32'h29b1_39c0;
		resetModel();
		pipe[0] = '0;
		pipe[1] = '0;

		// all flags stay low through reset and the first cycle after it
		for (int k = 1; k <= RESET_CYCLES; k++) begin
			@(posedge clk);
			if (k == RESET_CYCLES)
				rstN <= 1'b1;
			@(negedge clk);
			checkOutput('0);
		end

		// sweep a grid across and around each start position
		for (int j = 0; j < NUM_ENEMIES; j++) begin
			for (int oy = -4; oy < 26; oy += 3) begin
				for (int ox = -4; ox < 26; ox += 3) begin
					px.x = coordT'(modelX[j] + ox);
					px.y = coordT'(modelY[j] + oy);
					runCycle(px, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, speedT'(4));
				end
			end
		end

		randomPhase(MOTION_CYCLES, 10, 5, 0, 0, 0);
		randomPhase(ZONE_CYCLES, 10, 2, 0, 0, 0);
		randomPhase(EVENT_CYCLES, 5, 2, 20, 0, 0);
		randomPhase(SHOT_CYCLES, 5, 2, 10, 3, 1);

		// let the last pixels leave the pipeline
		for (int k = 0; k < DRAIN_CYCLES; k++) begin
			runCycle('0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, speedT'(4));
		end

		$display("Regression passed");
		$finish;
	end

endmodule

//--- tb/enemyStock_sva.sv
/*
  Output sanity checks on drawReq, bound into enemyStockManager.
  All properties are disabled while rstN is low.
*/

`timescale 1ns/1ns

module enemyStockSva import enemyPkg::*; (
	input logic    clk,
	input logic    rstN,
	input drawReqT drawReq
);

	// a body hit always masks the heads-up request
	bodyMasksUp: assert property (@(posedge clk) disable iff (!rstN)
		drawReq.enemyDrawReq |-> !drawReq.headsUpDrawReq)
		else $error("body request seen together with a heads-up request");

	offsetsIdle: assert property (@(posedge clk) disable iff (!rstN)
		!drawReq.enemyDrawReq |-> (drawReq.offsetX == '0 && drawReq.offsetY == '0))
		else $error("offsets are not zero without a body request");

	offsetsInBody: assert property (@(posedge clk) disable iff (!rstN)
		(drawReq.offsetX < coordT'(ENEMY_WIDTH)) && (drawReq.offsetY < coordT'(ENEMY_HEIGHT)))
		else $error("offsets fall outside the enemy body");

endmodule

bind enemyStockManager enemyStockSva sva (
	.clk    (clk),
	.rstN   (rstN),
	.drawReq(drawReq)
);
